/* source/dcache_pkg.sv */
package dcache_pkg;

	// cache geometry
	localparam int NUM_WAYS       = 4;
	localparam int WORDS_PER_LINE = 8;
	localparam int NUM_SETS       = 16;

	// address fields from the top are tag, index, word and byte
	localparam int OFFSET_W   = 5;
	localparam int INDEX_W    = 4;
	localparam int TAG_W      = 23;
	localparam int WAY_W      = 2;
	localparam int WORD_SEL_W = 3;

	typedef logic [31:0]             word_t;
	typedef logic [31:0]             addr_t;
	typedef logic [3:0]              strb_t;
	typedef logic [TAG_W-1:0]        tag_t;
	typedef logic [INDEX_W-1:0]      index_t;
	typedef logic [WAY_W-1:0]        way_t;
	typedef logic [WORD_SEL_W-1:0]   wsel_t;
	// root in bit 2, leaf for ways 0/1 in bit 0, leaf for ways 2/3 in bit 1
	typedef logic [2:0]              plru_t;

	typedef enum logic [2:0] {
		INVALIDATE,
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL,
		RESPOND
	} ctrl_state_e;

	function automatic index_t addr_index(input addr_t addr);
		return addr[OFFSET_W +: INDEX_W];
	endfunction

	function automatic tag_t addr_tag(input addr_t addr);
		return addr[OFFSET_W + INDEX_W +: TAG_W];
	endfunction

	function automatic wsel_t addr_word(input addr_t addr);
		return addr[OFFSET_W-1 -: WORD_SEL_W];
	endfunction

	function automatic addr_t line_base(input tag_t tag, input index_t index);
		return {tag, index, {OFFSET_W{1'b0}}};
	endfunction

	function automatic word_t byte_merge(input word_t old_word, input word_t new_word,
		input strb_t strb);
		word_t merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				merged[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return merged;
	endfunction

endpackage

/* source/xfer_if.sv */
`timescale 1ns/10ps

interface xfer_if import dcache_pkg::*; ();
	logic   wb_start;
	logic   fill_start;
	index_t set;
	way_t   way;
	tag_t   victim_tag;
	addr_t  fill_addr;
	wsel_t  req_word;
	logic   req_we;
	strb_t  req_wstrb;
	word_t  req_wdata;
	logic   done;
	// merged requested word held until the next fill
	word_t  fill_word;

	modport ctrl (
		output wb_start, fill_start, set, way, victim_tag, fill_addr,
		output req_word, req_we, req_wstrb, req_wdata,
		input  done, fill_word
	);

	modport xfer (
		input  wb_start, fill_start, set, way, victim_tag, fill_addr,
		input  req_word, req_we, req_wstrb, req_wdata,
		output done, fill_word
	);
endinterface

/* source/tag_array.sv */
`timescale 1ns/10ps

module tag_array import dcache_pkg::*; (
	input  logic                           i_clk,
	input  index_t                         i_raddr,
	output logic [NUM_WAYS-1:0][TAG_W:0]   o_rdata,
	input  logic [NUM_WAYS-1:0]            i_we,
	input  index_t                         i_waddr,
	input  logic                           i_wvalid,
	input  tag_t                           i_wdata
);

	logic valid_mem [NUM_WAYS][NUM_SETS];
	tag_t tag_mem   [NUM_WAYS][NUM_SETS];

	// one write enable per way with shared address and data
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (i_we[w]) begin
				valid_mem[w][i_waddr] <= i_wvalid;
				tag_mem[w][i_waddr]   <= i_wdata;
			end
		end
	end

	// registered read with the valid bit on top
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			o_rdata[w] <= {valid_mem[w][i_raddr], tag_mem[w][i_raddr]};
		end
	end

endmodule

/* source/data_array.sv */
`timescale 1ns/10ps

module data_array import dcache_pkg::*; (
	input  logic                                       i_clk,
	// port A reads whole lines and writes bytes on store hits
	input  index_t                                     i_a_raddr,
	output word_t [NUM_WAYS-1:0][WORDS_PER_LINE-1:0]   o_a_rline,
	input  logic [NUM_WAYS-1:0]                        i_a_we,
	input  wsel_t                                      i_a_wsel,
	input  strb_t                                      i_a_wstrb,
	input  word_t                                      i_a_wdata,
	// port B moves single words for write-back and refill
	input  index_t                                     i_b_addr,
	input  way_t                                       i_b_way,
	input  wsel_t                                      i_b_wsel,
	input  logic                                       i_b_we,
	input  word_t                                      i_b_wdata,
	output word_t                                      o_b_rdata
);

	word_t mem [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];

	always_ff @(posedge i_clk) begin
		// store hit writes into the set being looked up
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (i_a_we[w])
				mem[w][i_a_raddr][i_a_wsel] <=
					byte_merge(mem[w][i_a_raddr][i_a_wsel], i_a_wdata, i_a_wstrb);
		end
		if (i_b_we)
			mem[i_b_way][i_b_addr][i_b_wsel] <= i_b_wdata;
	end

	always_ff @(posedge i_clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int k = 0; k < WORDS_PER_LINE; k++) begin
				o_a_rline[w][k] <= mem[w][i_a_raddr][k];
			end
		end
		o_b_rdata <= mem[i_b_way][i_b_addr][i_b_wsel];
	end

endmodule

/* source/plru_table.sv */
`timescale 1ns/10ps

module plru_table import dcache_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,
	input  index_t i_set,
	output way_t   o_victim,
	input  logic   i_touch,
	input  way_t   i_way
);

	plru_t bits [NUM_SETS];
	plru_t cur;

	assign cur = bits[i_set];

	// root picks the half, the leaf of that half picks the way
	always_comb begin
		if (!cur[2])
			o_victim = {1'b0, cur[0]};
		else
			o_victim = {1'b1, cur[1]};
	end

	// point every bit on the touched path away from the touched way
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				bits[s] <= '0;
			end
		end else if (i_touch) begin
			bits[i_set][2] <= ~i_way[1];
			if (!i_way[1])
				bits[i_set][0] <= ~i_way[0];
			else
				bits[i_set][1] <= ~i_way[0];
		end
	end

endmodule

/* source/line_xfer.sv */
`timescale 1ns/10ps

module line_xfer import dcache_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	xfer_if.xfer        xfer,
	// memory read
	output logic        o_rd_req,
	output addr_t       o_rd_addr,
	input  logic        i_rd_valid,
	input  word_t       i_rd_data,
	// memory write
	output logic        o_wr_valid,
	output addr_t       o_wr_addr,
	output word_t       o_wr_data,
	// data array port B
	output index_t      o_b_addr,
	output way_t        o_b_way,
	output wsel_t       o_b_wsel,
	output logic        o_b_we,
	output word_t       o_b_wdata,
	input  word_t       i_b_rdata
);

	logic   wb_busy;
	logic   fill_busy;
	wsel_t  rd_cnt;
	wsel_t  fill_cnt;
	logic   beat_valid;
	wsel_t  beat_sel;
	logic   done_q;
	index_t set_q;
	way_t   way_q;
	tag_t   tag_q;
	word_t  fill_word_q;

	logic   rd_issue;
	wsel_t  rd_sel;
	logic   fill_beat;
	logic   is_req_word;
	word_t  beat_word;

	// word 0 is read in the start cycle with the controller's set and way
	assign rd_issue    = xfer.wb_start | wb_busy;
	assign rd_sel      = xfer.wb_start ? '0 : rd_cnt;
	assign fill_beat   = fill_busy & i_rd_valid;
	assign is_req_word = fill_cnt == xfer.req_word;
	assign beat_word   = (is_req_word && xfer.req_we) ?
		byte_merge(i_rd_data, xfer.req_wdata, xfer.req_wstrb) : i_rd_data;

	assign o_b_addr  = xfer.wb_start ? xfer.set : set_q;
	assign o_b_way   = xfer.wb_start ? xfer.way : way_q;
	assign o_b_wsel  = fill_busy ? fill_cnt : rd_sel;
	assign o_b_we    = fill_beat;
	assign o_b_wdata = beat_word;

	// array read data lines up with the beat registered a cycle earlier
	assign o_wr_valid = beat_valid;
	assign o_wr_addr  = line_base(tag_q, set_q) | addr_t'({beat_sel, 2'b00});
	assign o_wr_data  = i_b_rdata;

	assign xfer.done      = done_q;
	assign xfer.fill_word = fill_word_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wb_busy    <= 1'b0;
			fill_busy  <= 1'b0;
			rd_cnt     <= '0;
			fill_cnt   <= '0;
			beat_valid <= 1'b0;
			done_q     <= 1'b0;
			o_rd_req   <= 1'b0;
		end else begin
			o_rd_req   <= xfer.fill_start;
			beat_valid <= rd_issue;
			done_q     <= (beat_valid && beat_sel == '1) || (fill_beat && fill_cnt == '1);

			if (xfer.wb_start) begin
				wb_busy <= 1'b1;
				rd_cnt  <= wsel_t'(1);
			end else if (wb_busy) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == '1)
					wb_busy <= 1'b0;
			end

			if (xfer.fill_start) begin
				fill_busy <= 1'b1;
				fill_cnt  <= '0;
			end else if (fill_beat) begin
				fill_cnt <= fill_cnt + 1'b1;
				if (fill_cnt == '1)
					fill_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		beat_sel <= rd_sel;
		if (xfer.wb_start || xfer.fill_start) begin
			set_q <= xfer.set;
			way_q <= xfer.way;
		end
		if (xfer.wb_start)
			tag_q <= xfer.victim_tag;
		if (xfer.fill_start)
			o_rd_addr <= xfer.fill_addr;
		// keep the requested word for the response
		if (fill_beat && is_req_word)
			fill_word_q <= beat_word;
	end

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; (
	input  logic                                       i_clk,
	input  logic                                       i_rst,
	// client
	input  logic                                       i_req,
	input  logic                                       i_we,
	input  addr_t                                      i_addr,
	input  strb_t                                      i_wstrb,
	input  word_t                                      i_wdata,
	output logic                                       o_busy,
	output logic                                       o_ack,
	output word_t                                      o_rdata,
	xfer_if.ctrl                                       xfer,
	// tag array
	output index_t                                     o_tag_raddr,
	input  logic [NUM_WAYS-1:0][TAG_W:0]               i_tag_rdata,
	output logic [NUM_WAYS-1:0]                        o_tag_we,
	output index_t                                     o_tag_waddr,
	output logic                                       o_tag_wvalid,
	output tag_t                                       o_tag_wdata,
	// data array port A
	output index_t                                     o_dat_raddr,
	input  word_t [NUM_WAYS-1:0][WORDS_PER_LINE-1:0]   i_dat_rline,
	output logic [NUM_WAYS-1:0]                        o_dat_we,
	output wsel_t                                      o_dat_wsel,
	output strb_t                                      o_dat_wstrb,
	output word_t                                      o_dat_wdata,
	// lru
	output index_t                                     o_lru_set,
	input  way_t                                       i_lru_victim,
	output logic                                       o_lru_touch,
	output way_t                                       o_lru_way
);

	ctrl_state_e         state;
	ctrl_state_e         state_nxt;
	index_t              inv_cnt;
	addr_t               req_addr;
	logic                req_we;
	strb_t               req_wstrb;
	word_t               req_wdata;
	way_t                victim_q;

	index_t              req_index;
	tag_t                req_tag;
	wsel_t               req_word;
	index_t              rd_index;
	logic [NUM_WAYS-1:0] hit_vec;
	logic                hit;
	way_t                hit_way;
	logic                victim_valid;
	logic                lookup_hit;
	logic                lookup_miss;
	logic                fill_done;

	assign req_index = addr_index(req_addr);
	assign req_tag   = addr_tag(req_addr);
	assign req_word  = addr_word(req_addr);

	// arrays see the incoming address while idle
	assign rd_index = (state == IDLE) ? addr_index(i_addr) : req_index;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_vec[w] = i_tag_rdata[w][TAG_W] && (i_tag_rdata[w][TAG_W-1:0] == req_tag);
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
	end

	assign hit          = |hit_vec;
	assign victim_valid = i_tag_rdata[i_lru_victim][TAG_W];
	assign lookup_hit   = (state == LOOKUP) && hit;
	assign lookup_miss  = (state == LOOKUP) && !hit;
	assign fill_done    = (state == REFILL) && xfer.done;

	always_comb begin
		state_nxt = state;
		case (state)
			INVALIDATE: if (inv_cnt == index_t'(NUM_SETS - 1)) state_nxt = IDLE;
			IDLE:       if (i_req) state_nxt = LOOKUP;
			LOOKUP: begin
				if (hit)
					state_nxt = IDLE;
				else if (victim_valid)
					state_nxt = WRITEBACK;
				else
					state_nxt = REFILL;
			end
			WRITEBACK:  if (xfer.done) state_nxt = REFILL;
			REFILL:     if (xfer.done) state_nxt = RESPOND;
			RESPOND:    state_nxt = IDLE;
			default:    state_nxt = INVALIDATE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state   <= INVALIDATE;
			inv_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == INVALIDATE)
				inv_cnt <= inv_cnt + 1'b1;
		end
	end

	// request capture and victim choice
	always_ff @(posedge i_clk) begin
		if (state == IDLE && i_req) begin
			req_addr  <= i_addr;
			req_we    <= i_we;
			req_wstrb <= i_wstrb;
			req_wdata <= i_wdata;
		end
		if (state == LOOKUP)
			victim_q <= i_lru_victim;
	end

	assign o_busy  = state != IDLE;
	assign o_ack   = lookup_hit || (state == RESPOND);
	assign o_rdata = (state == RESPOND) ? xfer.fill_word : i_dat_rline[hit_way][req_word];

	// clear one set per cycle after reset, else install the refilled tag
	assign o_tag_raddr  = rd_index;
	assign o_tag_we     = (state == INVALIDATE) ? '1 :
		fill_done ? (NUM_WAYS'(1) << victim_q) : '0;
	assign o_tag_waddr  = (state == INVALIDATE) ? inv_cnt : req_index;
	assign o_tag_wvalid = state != INVALIDATE;
	assign o_tag_wdata  = req_tag;

	assign o_dat_raddr = rd_index;
	assign o_dat_we    = (lookup_hit && req_we) ? hit_vec : '0;
	assign o_dat_wsel  = req_word;
	assign o_dat_wstrb = req_wstrb;
	assign o_dat_wdata = req_wdata;

	assign o_lru_set   = req_index;
	assign o_lru_touch = lookup_hit || fill_done;
	assign o_lru_way   = (state == LOOKUP) ? hit_way : victim_q;

	// refill starts at once when the victim is empty
	assign xfer.wb_start   = lookup_miss && victim_valid;
	assign xfer.fill_start = (lookup_miss && !victim_valid) ||
		((state == WRITEBACK) && xfer.done);
	assign xfer.set        = req_index;
	assign xfer.way        = (state == LOOKUP) ? i_lru_victim : victim_q;
	assign xfer.victim_tag = i_tag_rdata[i_lru_victim][TAG_W-1:0];
	assign xfer.fill_addr  = line_base(req_tag, req_index);
	assign xfer.req_word   = req_word;
	assign xfer.req_we     = req_we;
	assign xfer.req_wstrb  = req_wstrb;
	assign xfer.req_wdata  = req_wdata;

endmodule

/* source/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rst,
	input  logic   i_req,
	input  logic   i_we,
	input  addr_t  i_addr,
	input  strb_t  i_wstrb,
	input  word_t  i_wdata,
	output logic   o_busy,
	output logic   o_ack,
	output word_t  o_rdata,
	output logic   o_rd_req,
	output addr_t  o_rd_addr,
	input  logic   i_rd_valid,
	input  word_t  i_rd_data,
	output logic   o_wr_valid,
	output addr_t  o_wr_addr,
	output word_t  o_wr_data
);

	index_t                                   tag_raddr;
	logic [NUM_WAYS-1:0][TAG_W:0]             tag_rdata;
	logic [NUM_WAYS-1:0]                      tag_we;
	index_t                                   tag_waddr;
	logic                                     tag_wvalid;
	tag_t                                     tag_wdata;

	index_t                                   dat_raddr;
	word_t [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] dat_rline;
	logic [NUM_WAYS-1:0]                      dat_we;
	wsel_t                                    dat_wsel;
	strb_t                                    dat_wstrb;
	word_t                                    dat_wdata;

	index_t                                   b_addr;
	way_t                                     b_way;
	wsel_t                                    b_wsel;
	logic                                     b_we;
	word_t                                    b_wdata;
	word_t                                    b_rdata;

	index_t                                   lru_set;
	way_t                                     lru_victim;
	logic                                     lru_touch;
	way_t                                     lru_way;

	xfer_if u_xfer_if ();

	dcache_ctrl u_ctrl (
		.i_clk, .i_rst, .i_req, .i_we, .i_addr, .i_wstrb, .i_wdata,
		.o_busy, .o_ack, .o_rdata,
		.xfer         (u_xfer_if.ctrl),
		.o_tag_raddr  (tag_raddr),
		.i_tag_rdata  (tag_rdata),
		.o_tag_we     (tag_we),
		.o_tag_waddr  (tag_waddr),
		.o_tag_wvalid (tag_wvalid),
		.o_tag_wdata  (tag_wdata),
		.o_dat_raddr  (dat_raddr),
		.i_dat_rline  (dat_rline),
		.o_dat_we     (dat_we),
		.o_dat_wsel   (dat_wsel),
		.o_dat_wstrb  (dat_wstrb),
		.o_dat_wdata  (dat_wdata),
		.o_lru_set    (lru_set),
		.i_lru_victim (lru_victim),
		.o_lru_touch  (lru_touch),
		.o_lru_way    (lru_way)
	);

	tag_array u_tag_array (
		.i_clk, .i_raddr (tag_raddr), .o_rdata (tag_rdata), .i_we (tag_we),
		.i_waddr (tag_waddr), .i_wvalid (tag_wvalid), .i_wdata (tag_wdata)
	);

	data_array u_data_array (
		.i_clk,
		.i_a_raddr (dat_raddr), .o_a_rline (dat_rline), .i_a_we (dat_we),
		.i_a_wsel (dat_wsel), .i_a_wstrb (dat_wstrb), .i_a_wdata (dat_wdata),
		.i_b_addr (b_addr), .i_b_way (b_way), .i_b_wsel (b_wsel),
		.i_b_we (b_we), .i_b_wdata (b_wdata), .o_b_rdata (b_rdata)
	);

	plru_table u_plru_table (
		.i_clk, .i_rst, .i_set (lru_set), .o_victim (lru_victim),
		.i_touch (lru_touch), .i_way (lru_way)
	);

	line_xfer u_line_xfer (
		.i_clk, .i_rst,
		.xfer (u_xfer_if.xfer),
		.o_rd_req, .o_rd_addr, .i_rd_valid, .i_rd_data,
		.o_wr_valid, .o_wr_addr, .o_wr_data,
		.o_b_addr (b_addr), .o_b_way (b_way), .o_b_wsel (b_wsel),
		.o_b_we (b_we), .o_b_wdata (b_wdata), .i_b_rdata (b_rdata)
	);

endmodule

/* test/dcache_props.sv */
`timescale 1ns/10ps

module dcache_props import dcache_pkg::*; (
	input logic i_clk,
	input logic i_rst,
	input logic i_req,
	input logic o_busy,
	input logic o_ack,
	input logic o_rd_req,
	input logic o_wr_valid
);

	logic       req_open;
	logic       req_q;
	logic [3:0] wr_run;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			req_open <= 1'b0;
			req_q    <= 1'b0;
			wr_run   <= '0;
		end else begin
			req_q  <= i_req;
			wr_run <= o_wr_valid ? wr_run + 1'b1 : '0;
			if (i_req)
				req_open <= 1'b1;
			else if (o_ack)
				req_open <= 1'b0;
		end
	end

	ack_after_req: assert property (@(posedge i_clk) disable iff (i_rst)
		o_ack |-> req_open)
		else $error("o_ack with no open request");

	req_when_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		i_req |-> !o_busy)
		else $error("i_req while o_busy is high");

	// a lookup without ack is a miss, so a line transfer starts next cycle
	hit_ack_next: assert property (@(posedge i_clk) disable iff (i_rst)
		(req_q && !o_ack) |=> (o_wr_valid || o_rd_req))
		else $error("lookup neither acked nor started a transfer");

	wr_burst_max: assert property (@(posedge i_clk) disable iff (i_rst)
		o_wr_valid |-> (wr_run < 4'(WORDS_PER_LINE)))
		else $error("write-back burst longer than one line");

	wr_burst_len: assert property (@(posedge i_clk) disable iff (i_rst)
		(!o_wr_valid && wr_run != '0) |-> (wr_run == 4'(WORDS_PER_LINE)))
		else $error("write-back burst shorter than one line");

endmodule

bind dcache_top dcache_props u_props (.*);

/* test/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ();

	localparam int NUM_DIRECTED = 61;
	localparam int NUM_RANDOM   = 400;
	localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * 60 + 2000;

	logic  i_clk = 1'b0;
	logic  i_rst;
	logic  i_req;
	logic  i_we;
	addr_t i_addr;
	strb_t i_wstrb;
	word_t i_wdata;
	logic  o_busy;
	logic  o_ack;
	word_t o_rdata;
	logic  o_rd_req;
	addr_t o_rd_addr;
	logic  i_rd_valid;
	word_t i_rd_data;
	logic  o_wr_valid;
	addr_t o_wr_addr;
	word_t o_wr_data;

	// architectural contents and what the memory itself holds
	word_t shadow  [addr_t];
	word_t backing [addr_t];

	// reference cache state
	tag_t  ref_tag   [NUM_SETS][NUM_WAYS];
	logic  ref_valid [NUM_SETS][NUM_WAYS];
	plru_t ref_plru  [NUM_SETS];

	logic  exp_hit;
	logic  exp_we;
	logic  exp_wb;
	addr_t exp_wb_base;
	addr_t exp_fill;
	word_t exp_rdata;
	int    rd_count;
	int    wb_count;
	int    ack_count;
	int    rd_mark;
	int    wb_mark;
	int    req_total;
	int    cyc;
	logic  req_open;
	int    wait_cyc;

	dcache_top i_dut (.*);

	always #4 i_clk = ~i_clk;

	task automatic end_failed();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			end_failed();
		end
	endtask

	task automatic report_error(input string why);
		$display("ERROR: %s", why);
		end_failed();
	endtask

	// every word of memory starts with a value unique to its address
	function automatic word_t init_word(input addr_t a);
		return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
	endfunction

	function automatic word_t shadow_rd(input addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return init_word(a);
	endfunction

	function automatic word_t backing_rd(input addr_t a);
		if (backing.exists(a))
			return backing[a];
		return init_word(a);
	endfunction

	function automatic word_t apply_strobe(input word_t old_w, input word_t new_w,
		input strb_t s);
		word_t r;
		for (int b = 0; b < 4; b++)
			r[b*8 +: 8] = s[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
		return r;
	endfunction

	function automatic addr_t make_addr(input int unsigned tag, input int unsigned idx,
		input int unsigned w);
		return {tag[TAG_W-1:0], idx[INDEX_W-1:0], w[WORD_SEL_W-1:0], 2'b00};
	endfunction

	// root selects the half, the leaf of that half selects the way
	function automatic way_t plru_victim(input plru_t t);
		if (t[2])
			return {1'b1, t[1]};
		return {1'b0, t[0]};
	endfunction

	function automatic plru_t plru_touch(input plru_t t, input way_t w);
		plru_t n;
		n    = t;
		n[2] = ~w[1];
		if (w[1])
			n[1] = ~w[0];
		else
			n[0] = ~w[0];
		return n;
	endfunction

	// predicts hit or miss and the evicted line, then updates the model
	function automatic logic ref_access(input addr_t a);
		index_t idx;
		tag_t   tag;
		way_t   way;
		logic   hit;
		idx = a[OFFSET_W +: INDEX_W];
		tag = a[31 -: TAG_W];
		hit = 1'b0;
		way = '0;
		exp_wb = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		if (!hit) begin
			way = plru_victim(ref_plru[idx]);
			exp_wb = ref_valid[idx][way];
			exp_wb_base = {ref_tag[idx][way], idx, {OFFSET_W{1'b0}}};
			ref_valid[idx][way] = 1'b1;
			ref_tag[idx][way] = tag;
		end
		ref_plru[idx] = plru_touch(ref_plru[idx], way);
		return hit;
	endfunction

	task automatic run_access(input logic we, input addr_t addr, input strb_t strb,
		input word_t wdata);
		addr_t wa;
		int    ack_mark;
		wa        = {addr[31:2], 2'b00};
		exp_we    = we;
		exp_fill  = {addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
		exp_rdata = shadow_rd(wa);
		exp_hit   = ref_access(wa);
		if (we)
			shadow[wa] = apply_strobe(exp_rdata, wdata, strb);
		rd_mark  = rd_count;
		wb_mark  = wb_count;
		ack_mark = ack_count;
		i_req   <= 1'b1;
		i_we    <= we;
		i_addr  <= addr;
		i_wstrb <= strb;
		i_wdata <= wdata;
		@(posedge i_clk);
		i_req <= 1'b0;
		while (ack_count == ack_mark)
			@(posedge i_clk);
		compare("o_rd_req count", 32'(rd_count - rd_mark), exp_hit ? 32'd0 : 32'd1);
		compare("o_wr_valid beats", 32'(wb_count - wb_mark),
			exp_wb ? 32'(WORDS_PER_LINE) : 32'd0);
		req_total++;
	endtask

	// response checker
	always @(negedge i_clk) begin
		if (req_open)
			wait_cyc++;
		if (i_req) begin
			req_open = 1'b1;
			wait_cyc = 0;
		end
		if (o_ack) begin
			if (!req_open)
				report_error("o_ack came without an open request");
			if (exp_hit)
				compare("ack latency", 32'(wait_cyc), 32'd1);
			if (!exp_we)
				compare("o_rdata", o_rdata, exp_rdata);
			req_open = 1'b0;
			ack_count++;
		end
	end

	// write-back beats carry the predicted victim line in order
	always @(negedge i_clk) begin
		if (o_wr_valid) begin
			if (!exp_wb)
				report_error("write-back beat without a predicted eviction");
			compare("o_wr_addr", o_wr_addr, exp_wb_base + 32'((wb_count - wb_mark) * 4));
			compare("o_wr_data", o_wr_data, shadow_rd(o_wr_addr));
			backing[o_wr_addr] = o_wr_data;
			wb_count++;
		end
	end

	// memory read side with random latency and random gaps between beats
	initial begin : mem_model
		addr_t fill_addr;
		i_rd_valid <= 1'b0;
		i_rd_data  <= '0;
		forever begin
			@(negedge i_clk);
			if (o_rd_req) begin
				rd_count++;
				compare("o_rd_addr", o_rd_addr, exp_fill);
				fill_addr = o_rd_addr;
				repeat (2 + $urandom_range(3)) @(posedge i_clk);
				for (int k = 0; k < WORDS_PER_LINE; k++) begin
					if ($urandom_range(3) == 0) begin
						i_rd_valid <= 1'b0;
						@(posedge i_clk);
					end
					i_rd_valid <= 1'b1;
					i_rd_data  <= backing_rd(fill_addr + 32'(k * 4));
					@(posedge i_clk);
				end
				i_rd_valid <= 1'b0;
			end
		end
	end

	always @(posedge i_clk) begin
		cyc++;
		if (cyc > CYCLE_LIMIT)
			report_error("timeout, the run went past its cycle limit");
	end

	initial begin : stimulus
		int unsigned n;
		int          busy_cyc;
		void'($urandom(32'hc1b9_18b6));
		for (int s = 0; s < NUM_SETS; s++) begin
			ref_plru[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
				ref_valid[s][w] = 1'b0;
		end
		i_rst   <= 1'b1;
		i_req   <= 1'b0;
		i_we    <= 1'b0;
		i_addr  <= '0;
		i_wstrb <= '0;
		i_wdata <= '0;
		repeat (10) @(posedge i_clk);
		i_rst <= 1'b0;

		// invalidation sweep after reset
		busy_cyc = 0;
		@(negedge i_clk);
		while (o_busy) begin
			busy_cyc++;
			@(negedge i_clk);
		end
		compare("invalidate cycles", 32'(busy_cyc), 32'(NUM_SETS));
		@(posedge i_clk);

		// cold misses, then hits on the same lines
		for (int k = 0; k < 8; k++)
			run_access(1'b0, make_addr(32'h100, 8 + k, $urandom_range(7)), 4'h0, 32'h0);
		for (int k = 0; k < 8; k++)
			run_access(1'b0, make_addr(32'h100, 8 + k, 7 - k), 4'h0, 32'h0);

		// stores on resident lines, then on new lines
		for (int k = 0; k < 16; k++) begin
			n = (k < 8) ? 32'h100 : 32'h200;
			run_access(1'b1, make_addr(n, 8 + k % 8, k % 8),
				4'($urandom_range(15)), $urandom);
			run_access(1'b0, make_addr(n, 8 + k % 8, k % 8), 4'h0, 32'h0);
		end

		// fill all four ways of set 2 so that a fifth line evicts
		for (int k = 0; k < NUM_WAYS; k++) begin
			run_access(1'b0, make_addr(32'h300 + k, 2, 0), 4'h0, 32'h0);
			run_access(1'b1, make_addr(32'h300 + k, 2, k),
				4'($urandom_range(15)), $urandom);
		end
		run_access(1'b0, make_addr(32'h304, 2, 5), 4'h0, 32'h0);
		compare("o_wr_valid beats", 32'(wb_count - wb_mark), 32'(WORDS_PER_LINE));
		for (int k = 0; k < NUM_WAYS; k++)
			run_access(1'b0, make_addr(32'h300 + k, 2, k), 4'h0, 32'h0);

		// 64 lines folded onto sets 0 to 3
		for (int r = 0; r < NUM_RANDOM; r++) begin
			n = $urandom_range(63);
			run_access(1'($urandom_range(1)),
				make_addr(32'h5a00 + (n >> 2) * 32'h123, n & 3, $urandom_range(7)),
				4'($urandom_range(15)), $urandom);
		end

		repeat (4) @(posedge i_clk);
		$display("%0d requests, %0d refills, %0d write-back beats",
			req_total, rd_count, wb_count);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* sources.f */
source/dcache_pkg.sv
source/xfer_if.sv
source/tag_array.sv
source/data_array.sv
source/plru_table.sv
source/line_xfer.sv
source/dcache_ctrl.sv
source/dcache_top.sv
test/dcache_props.sv
test/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build the dcache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module dcache_tb -f sources.f -o dcache_sim
./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
# an assertion stop ends the run without a verdict line
if ! grep -q "STATUS: PASS" sim.log; then
	exit 1
fi
